/* run_sim.sh */
#!/bin/sh
# compile and run the bundler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hdc_bundler \
    -f verilog.f -o sim_hdc_bundler || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_hdc_bundler 2>&1)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || { echo "run failed"; exit 1; }

/* source/bundle_cmd_decode.sv */
`default_nettype none

module bundle_cmd_decode #(

    // hypervector width
    parameter int DIM   = 64,

    // cores actually present
    parameter int CORES = 4

) (

    input  wire                                  clk,
    input  wire                                  reset,

    // command side
    input  wire                                  cmd_valid,
    input  wire hdc_pkg::cmd_word_u              cmd,

    // core c owns bits c*DIM upward
    input  wire  [CORES*DIM-1:0]                 core_data,

    // toward the counter bank
    output logic                                 acc_en,
    output logic                                 clr_en,
    output logic                                 rd_en,
    output logic [CORES-1:0]                     acc_mask,
    output logic [CORES*DIM-1:0]                 acc_data,
    output logic [hdc_pkg::CHUNK_IDX_W-1:0]      rd_chunk

);

    // opcode of the incoming word
    logic [hdc_pkg::OP_W-1:0] op;

    // one hot command kind, already qualified by cmd_valid
    logic                     is_acc;
    logic                     is_clr;
    logic                     is_rd;

    // opcode sits at the same bits in both views
    assign op = cmd.acc.op;

    assign is_acc = cmd_valid && (op == hdc_pkg::OP_ACCUM);
    assign is_clr = cmd_valid && (op == hdc_pkg::OP_CLEAR);
    assign is_rd  = cmd_valid && (op == hdc_pkg::OP_READ);

    // nop falls through all three compares
    // so nothing reaches the bank

    // enables are single cycle strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_en <= 1'b0;
            clr_en <= 1'b0;
            rd_en  <= 1'b0;
        end else begin
            acc_en <= is_acc;
            clr_en <= is_clr;
            rd_en  <= is_rd;
        end
    end

    // accumulate payload
    // mask bits above CORES are dropped here
    always_ff @(posedge clk) begin
        if (is_acc) begin
            acc_mask <= cmd.acc.core_mask[CORES-1:0];
            acc_data <= core_data;
        end
    end

    // read payload
    // index is taken raw, range check is left to the streamer
    always_ff @(posedge clk) begin
        if (is_rd) begin
            rd_chunk <= cmd.rd.chunk;
        end
    end

endmodule

`default_nettype wire

/* source/bundle_counter_bank.sv */
`default_nettype none

module bundle_counter_bank #(

    // number of counters
    parameter int DIM   = 64,

    // vote inputs per counter
    parameter int CORES = 4,

    // counter width, two's complement
    parameter int CNT_W = 6

) (

    input  wire                                  clk,
    input  wire                                  reset,

    // from the decoder
    input  wire                                  acc_en,
    input  wire                                  clr_en,
    input  wire                                  rd_en,
    input  wire  [CORES-1:0]                     acc_mask,
    input  wire  [CORES*DIM-1:0]                 acc_data,
    input  wire  [hdc_pkg::CHUNK_IDX_W-1:0]      rd_chunk,

    // toward the streamer
    output logic [DIM-1:0]                       sign_bits,
    output logic                                 sign_rd_en,
    output logic [hdc_pkg::CHUNK_IDX_W-1:0]      sign_rd_chunk

);

    // sum has to hold the counter plus up to CORES votes either way
    // one extra bit keeps the sign clear of overflow
    localparam int SUM_W = CNT_W + $clog2(CORES + 1) + 1;

    // saturation limits at sum width
    localparam logic signed [SUM_W-1:0] CNT_MAX = SUM_W'((1 << (CNT_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] CNT_MIN = -CNT_MAX - SUM_W'(1);

    // single votes
    localparam logic signed [SUM_W-1:0] VOTE_UP = SUM_W'(1);
    localparam logic signed [SUM_W-1:0] VOTE_DN = SUM_W'(-1);

    // one counter per dimension
    for (genvar d = 0; d < DIM; d++) begin : g_dim

        // counter state
        logic signed [CNT_W-1:0] cnt_q;

        // combined vote of the masked cores
        logic signed [SUM_W-1:0] votes;

        // counter plus votes, before clamping
        logic signed [SUM_W-1:0] total;

        // clamped next value
        logic signed [CNT_W-1:0] cnt_next;

        // each masked core pushes +1 for a one, -1 for a zero
        always_comb begin
            votes = '0;
            for (int c = 0; c < CORES; c++) begin
                if (acc_mask[c]) begin
                    votes = votes + (acc_data[c*DIM + d] ? VOTE_UP : VOTE_DN);
                end
            end
        end

        // sign extend the counter and add
        assign total = votes + SUM_W'(cnt_q);

        // clamp into the counter range
        always_comb begin
            if (total > CNT_MAX) begin
                cnt_next = CNT_W'(CNT_MAX);
            end else if (total < CNT_MIN) begin
                cnt_next = CNT_W'(CNT_MIN);
            end else begin
                cnt_next = CNT_W'(total);
            end
        end

        // clear and accumulate never come together
        // opcodes are exclusive
        always_ff @(posedge clk) begin
            if (reset || clr_en) begin
                cnt_q <= '0;
            end else if (acc_en) begin
                cnt_q <= cnt_next;
            end
        end

        // strictly positive gives one, a tie gives zero
        assign sign_bits[d] = !cnt_q[CNT_W-1] && (cnt_q != '0);

    end

    // read request slips one stage
    // it then lines up behind any accumulate sampled one edge earlier
    always_ff @(posedge clk) begin
        if (reset) begin
            sign_rd_en <= 1'b0;
        end else begin
            sign_rd_en <= rd_en;
        end
    end

    // index rides along with the strobe
    always_ff @(posedge clk) begin
        if (rd_en) begin
            sign_rd_chunk <= rd_chunk;
        end
    end

endmodule

`default_nettype wire

/* source/hdc_bundler_top.sv */
`default_nettype none

module hdc_bundler_top #(

    // hypervector width
    parameter int DIM     = 64,

    // core count, 1 up to hdc_pkg::MAX_CORES
    parameter int CORES   = 4,

    // per dimension counter width
    parameter int CNT_W   = 6,

    // stream slice width
    parameter int CHUNK_W = 16

) (

    input  wire                                  clk,
    input  wire                                  reset,

    // command in
    input  wire                                  cmd_valid,
    input  wire  [hdc_pkg::CMD_W-1:0]            cmd,
    input  wire  [CORES*DIM-1:0]                 core_data,

    // results out
    output logic                                 stream_v,
    output logic [CHUNK_W-1:0]                   stream_d,
    output logic [DIM-1:0]                       sign_bits

);

    // decoder to counter bank
    logic                                acc_en;
    logic                                clr_en;
    logic                                rd_en;
    logic [CORES-1:0]                    acc_mask;
    logic [CORES*DIM-1:0]                acc_data;
    logic [hdc_pkg::CHUNK_IDX_W-1:0]     rd_chunk;

    // counter bank to streamer
    logic                                sign_rd_en;
    logic [hdc_pkg::CHUNK_IDX_W-1:0]     sign_rd_chunk;

    // stage 1 registers the command
    bundle_cmd_decode #(
        .DIM   (DIM),
        .CORES (CORES)
    ) i_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .core_data (core_data),
        .acc_en    (acc_en),
        .clr_en    (clr_en),
        .rd_en     (rd_en),
        .acc_mask  (acc_mask),
        .acc_data  (acc_data),
        .rd_chunk  (rd_chunk)
    );

    // stage 2 updates counters and delays the read
    bundle_counter_bank #(
        .DIM   (DIM),
        .CORES (CORES),
        .CNT_W (CNT_W)
    ) i_execute (
        .clk           (clk),
        .reset         (reset),
        .acc_en        (acc_en),
        .clr_en        (clr_en),
        .rd_en         (rd_en),
        .acc_mask      (acc_mask),
        .acc_data      (acc_data),
        .rd_chunk      (rd_chunk),
        .sign_bits     (sign_bits),
        .sign_rd_en    (sign_rd_en),
        .sign_rd_chunk (sign_rd_chunk)
    );

    // stage 3 registers one slice with its strobe
    sign_chunk_streamer #(
        .DIM     (DIM),
        .CHUNK_W (CHUNK_W)
    ) i_result (
        .clk           (clk),
        .reset         (reset),
        .sign_bits     (sign_bits),
        .sign_rd_en    (sign_rd_en),
        .sign_rd_chunk (sign_rd_chunk),
        .stream_v      (stream_v),
        .stream_d      (stream_d)
    );

endmodule

`default_nettype wire

/* source/hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // command word layout
    localparam int OP_W        = 2;
    localparam int RSVD_W      = 6;
    localparam int MAX_CORES   = 8;
    localparam int CHUNK_IDX_W = 8;
    localparam int CMD_W       = 16;

    // opcodes in the top bits of the command
    localparam logic [OP_W-1:0] OP_NOP   = 2'd0;
    localparam logic [OP_W-1:0] OP_CLEAR = 2'd1;
    localparam logic [OP_W-1:0] OP_ACCUM = 2'd2;
    localparam logic [OP_W-1:0] OP_READ  = 2'd3;

    // one 16 bit command seen two ways
    // opcode and reserved bits sit at the same place in both views
    typedef union packed {

        // accumulate view
        // low byte picks which cores take part
        struct packed {
            logic [OP_W-1:0]      op;
            logic [RSVD_W-1:0]    rsvd;
            logic [MAX_CORES-1:0] core_mask;
        } acc;

        // read view
        // low byte is the chunk index
        struct packed {
            logic [OP_W-1:0]        op;
            logic [RSVD_W-1:0]      rsvd;
            logic [CHUNK_IDX_W-1:0] chunk;
        } rd;

    } cmd_word_u;

endpackage

`default_nettype wire

/* source/sign_chunk_streamer.sv */
`default_nettype none

module sign_chunk_streamer #(

    // full sign vector width
    parameter int DIM     = 64,

    // slice width, must divide DIM
    parameter int CHUNK_W = 16

) (

    input  wire                                  clk,
    input  wire                                  reset,

    // from the counter bank
    input  wire  [DIM-1:0]                       sign_bits,
    input  wire                                  sign_rd_en,
    input  wire  [hdc_pkg::CHUNK_IDX_W-1:0]      sign_rd_chunk,

    // result stream
    output logic                                 stream_v,
    output logic [CHUNK_W-1:0]                   stream_d

);

    // slices in one vector
    localparam int N_CHUNKS = DIM / CHUNK_W;

    // requested slice before the register
    logic [CHUNK_W-1:0] slice;

    // chunk k covers bits k*CHUNK_W upward
    // index past the end matches nothing and leaves zero
    always_comb begin
        slice = '0;
        for (int k = 0; k < N_CHUNKS; k++) begin
            if (int'(sign_rd_chunk) == k) begin
                slice = sign_bits[k*CHUNK_W +: CHUNK_W];
            end
        end
    end

    // data loads only on a request
    // valid goes high for the one cycle after it
    always_ff @(posedge clk) begin
        if (reset) begin
            stream_v <= 1'b0;
            stream_d <= '0;
        end else begin
            stream_v <= sign_rd_en;
            if (sign_rd_en) begin
                stream_d <= slice;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/hdc_bundler_props.sv */
`default_nettype none

module hdc_bundler_props (

    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  cmd_valid,
    input  wire  [hdc_pkg::CMD_W-1:0]            cmd,
    input  wire                                  stream_v

);

    timeunit 1ns;
    timeprecision 100ps;

    // read command seen at the top level port
    logic rd_cmd;

    // opcode sits in the top bits in both views
    assign rd_cmd = cmd_valid && (cmd[hdc_pkg::CMD_W-1 -: hdc_pkg::OP_W] == hdc_pkg::OP_READ);

    // strobe stays quiet while reset is held and one cycle after
    a_quiet_after_reset: assert property (@(posedge clk)
        ($past(reset) || $past(reset, 2)) |-> !stream_v)
        else $error("stream_v high during reset or right after it");

    // strobe is registered at the second edge after the read
    // so it is first sampled high at the third
    a_read_latency: assert property (@(posedge clk) disable iff (reset) rd_cmd |-> ##3 stream_v)
        else $error("read command without a strobe two cycles later");

    // no strobe without a read sampled three edges back
    a_no_spurious: assert property (@(posedge clk) disable iff (reset)
        stream_v |-> $past(rd_cmd, 3))
        else $error("stream_v high with no read two cycles earlier");

    // a two cycle strobe needs two reads in a row
    a_no_stretch: assert property (@(posedge clk) disable iff (reset)
        (stream_v && $past(stream_v)) |-> ($past(rd_cmd, 3) && $past(rd_cmd, 4)))
        else $error("stream_v held two cycles without two reads");

endmodule

`default_nettype wire

/* tests/tb_hdc_bundler.sv */
`default_nettype none

module tb_hdc_bundler;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIM      = 64;
    localparam int CORES    = 4;
    localparam int CNT_W    = 6;
    localparam int CHUNK_W  = 16;
    localparam int N_CHUNKS = DIM / CHUNK_W;

    // saturation range of one counter
    localparam int CNT_HI = (1 << (CNT_W - 1)) - 1;
    localparam int CNT_LO = -(1 << (CNT_W - 1));

    // suite needs a few hundred cycles, saturation run is the longest
    localparam int MAX_CYCLES  = 2000;
    localparam int STROBE_WAIT = 8;

    logic                       clk;
    logic                       reset;
    logic                       cmd_valid;
    logic [hdc_pkg::CMD_W-1:0]  cmd;
    logic [CORES*DIM-1:0]       core_data;
    logic                       stream_v;
    logic [CHUNK_W-1:0]         stream_d;
    logic [DIM-1:0]             sign_bits;

    // reference counters, one per dimension
    int                         cnt_model [DIM];
    logic [31:0]                rng_state;
    int                         cycles;

    hdc_bundler_top #(
        .DIM     (DIM),
        .CORES   (CORES),
        .CNT_W   (CNT_W),
        .CHUNK_W (CHUNK_W)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .core_data (core_data),
        .stream_v  (stream_v),
        .stream_d  (stream_d),
        .sign_bits (sign_bits)
    );

    bind hdc_bundler_top hdc_bundler_props i_props (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .stream_v  (stream_v)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // hard stop if something hangs
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: tests still running after %0d cycles", cycles));
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_vector(output logic [DIM-1:0] v);
        for (int w = 0; w < DIM / 32; w++) begin
            rng_state = lcg_next(rng_state);
            v[w*32 +: 32] = rng_state;
        end
    endtask

    // one command for one cycle, returns 1 ns after the sampling edge
    task automatic send_cmd(input logic [1:0] op, input logic [7:0] field,
                            input logic [CORES*DIM-1:0] data);
        hdc_pkg::cmd_word_u w;
        w = '0;
        w.acc.op = op;
        if (op == hdc_pkg::OP_READ) begin
            w.rd.chunk = field;
        end else begin
            w.acc.core_mask = field;
        end
        cmd_valid = 1'b1;
        cmd       = w;
        core_data = data;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd       = '0;
        core_data = '0;
    endtask

    task automatic clear();
        foreach (cnt_model[d]) begin
            cnt_model[d] = 0;
        end
        send_cmd(hdc_pkg::OP_CLEAR, 8'h00, '0);
    endtask

    // +1 for a one, -1 for a zero, clamp after all votes
    task automatic accumulate(input logic [7:0] mask, input logic [CORES*DIM-1:0] data);
        int sum;
        for (int d = 0; d < DIM; d++) begin
            sum = cnt_model[d];
            for (int c = 0; c < CORES; c++) begin
                if (mask[c]) begin
                    sum += data[c*DIM + d] ? 1 : -1;
                end
            end
            if (sum > CNT_HI) sum = CNT_HI;
            if (sum < CNT_LO) sum = CNT_LO;
            cnt_model[d] = sum;
        end
        send_cmd(hdc_pkg::OP_ACCUM, mask, data);
    endtask

    // tie reads as zero, past the end reads as zero
    function automatic logic [CHUNK_W-1:0] expected_chunk(input int k);
        logic [CHUNK_W-1:0] e;
        e = '0;
        if (k < N_CHUNKS) begin
            for (int i = 0; i < CHUNK_W; i++) begin
                e[i] = (cnt_model[k*CHUNK_W + i] > 0);
            end
        end
        return e;
    endfunction

    task automatic read_check(input int k);
        logic [CHUNK_W-1:0] exp;
        int                 waited;
        exp    = expected_chunk(k);
        waited = 0;
        send_cmd(hdc_pkg::OP_READ, 8'(k), '0);
        while (!stream_v && waited < STROBE_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (stream_v)
            else abort_run($sformatf("no stream strobe came back for the read of chunk %0d", k));
        assert (stream_d === exp)
            else abort_run($sformatf("ERR %0t: chunk %0d read %h, expected %h",
                                     $time, k, stream_d, exp));
    endtask

    task automatic read_all();
        for (int k = 0; k < N_CHUNKS; k++) begin
            read_check(k);
        end
    endtask

    // sign follows one edge after the accumulate was sampled
    task automatic check_sign_bits(input logic [DIM-1:0] exp, input string what);
        @(posedge clk);
        #1;
        assert (sign_bits === exp)
            else abort_run($sformatf("ERR %0t: sign_bits %h, expected %h (%s)",
                                     $time, sign_bits, exp, what));
    endtask

    task automatic zero_after_reset_and_clear();
        logic [DIM-1:0] v;
        read_all();
        random_vector(v);
        accumulate(8'h0F, {CORES{v}});
        clear();
        read_all();
    endtask

    task automatic single_core_vector();
        logic [DIM-1:0]       v0;
        logic [CORES*DIM-1:0] data;
        clear();
        random_vector(v0);
        // other cores carry the opposite vector, masked off
        data          = {CORES{~v0}};
        data[DIM-1:0] = v0;
        accumulate(8'h01, data);
        check_sign_bits(v0, "core 0 alone");
        read_all();
    endtask

    task automatic majority_and_tie();
        logic [DIM-1:0] a;
        logic [DIM-1:0] b;
        logic [DIM-1:0] c;
        logic [DIM-1:0] x;
        random_vector(a);
        random_vector(b);
        random_vector(c);
        random_vector(x);
        clear();
        // core 3 and mask bits above CORES are off
        accumulate(8'hF7, {x, c, b, a});
        check_sign_bits((a & b) | (a & c) | (b & c), "three core majority");
        read_all();
        // two votes, disagreement lands on zero
        clear();
        accumulate(8'h03, {x, c, b, a});
        check_sign_bits(a & b, "two core tie");
        read_all();
    endtask

    task automatic saturation();
        logic [DIM-1:0] v;
        clear();
        random_vector(v);
        repeat (CNT_HI + 9) accumulate(8'h01, {CORES{v}});
        read_all();
        accumulate(8'h01, {CORES{~v}});
        check_sign_bits(v, "one opposite vote after saturation");
        // walking back from the limit ends at a tie or below
        repeat (CNT_HI - 1) accumulate(8'h01, {CORES{~v}});
        check_sign_bits('0, "walked back from saturation");
        read_all();
    endtask

    task automatic range_and_back_to_back();
        logic [DIM-1:0] v;
        clear();
        random_vector(v);
        // read goes out on the very next cycle
        accumulate(8'h01, {CORES{v}});
        read_check(1);
        read_check(N_CHUNKS);
        read_check(255);
    endtask

    task automatic random_traffic();
        logic [31:0]          r;
        logic [DIM-1:0]       v;
        logic [CORES*DIM-1:0] data;
        clear();
        for (int i = 0; i < 20; i++) begin
            for (int c = 0; c < CORES; c++) begin
                random_vector(v);
                data[c*DIM +: DIM] = v;
            end
            rng_state = lcg_next(rng_state);
            r         = rng_state;
            accumulate(r[31:24], data);
            // one index past the end shows up now and then
            read_check(int'(r[15:8]) % (N_CHUNKS + 1));
        end
        read_all();
    endtask

    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        core_data = '0;
        rng_state = 32'h929214a0;
        foreach (cnt_model[d]) begin
            cnt_model[d] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        zero_after_reset_and_clear();
        single_core_vector();
        majority_and_tie();
        saturation();
        range_and_back_to_back();
        random_traffic();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/hdc_pkg.sv
source/bundle_cmd_decode.sv
source/bundle_counter_bank.sv
source/sign_chunk_streamer.sv
source/hdc_bundler_top.sv
tests/hdc_bundler_props.sv
tests/tb_hdc_bundler.sv
